//--- hw/usb_bulk_pkg.sv
package usb_bulk_pkg;

  // stream byte and endpoint widths
  localparam int DATA_W = 8;
  localparam int ENDPT_W = 4;

  typedef logic [DATA_W-1:0] byte_t;  // one stream data byte
  typedef logic [ENDPT_W-1:0] endpt_t;  // usb endpoint number

  // telemetry is read back through bulk IN endpoint 2
  localparam endpt_t DEF_TELE_ENDPOINT = 4'd2;

  // queue depth in entries, must be a power of two
  localparam int DEF_TELE_DEPTH = 16;

  // fill level that forces bulk IN ready
  // equal to the depth, so only a full queue forces it
  localparam int DEF_READY_LEVEL = 16;

endpackage

//--- hw/usb_reset_sync.sv
`timescale 1ns/100ps
module usb_reset_sync (
  input  logic clock,
  input  logic areset_n,
  input  logic usb_reset_i,
  output logic reset_o,
  output logic reset_no
);

  logic [3:0] chain_q;  // fills with ones from bit 0 upward

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      chain_q <= 4'h0;
    end else begin
      // last stage also drops while the host holds the bus in reset
      chain_q <= {chain_q[2] & ~usb_reset_i, chain_q[1], chain_q[0], 1'b1};
    end
  end

  assign reset_no = chain_q[1];  // phy side reset, released early
  assign reset_o = ~chain_q[3];  // core reset, released last

  // core must never come out of reset ahead of the phy
  a_release_order: assert property (
    @(posedge clock) disable iff (!areset_n)
    !reset_o |-> reset_no
  ) else $error("core reset released before reset_no");

endmodule

//--- hw/telemetry_capture.sv
`timescale 1ns/100ps
module telemetry_capture #(
  parameter int TELE_DEPTH = usb_bulk_pkg::DEF_TELE_DEPTH,
  localparam int LEVEL_W = $clog2(TELE_DEPTH) + 1
) (
  input  logic                clock,
  input  logic                reset_i,
  input  usb_bulk_pkg::byte_t status_i,
  input  logic                drain_i,
  output logic                tele_tvalid_o,
  input  logic                tele_tready_i,
  output logic                tele_tlast_o,
  output usb_bulk_pkg::byte_t tele_tdata_o,
  output logic [LEVEL_W-1:0]  tele_level_o,
  output logic                has_telemetry_o
);

  import usb_bulk_pkg::*;

  localparam int PTR_W = $clog2(TELE_DEPTH);
  localparam int HAS_LEVEL = 4;  // minimum fill worth reporting

  byte_t mem_q [TELE_DEPTH];  // circular status queue

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [LEVEL_W-1:0] level_q;
  byte_t last_q;  // last byte that went into the queue
  logic has_q;

  logic change_w;
  logic full_w;
  logic push_w;
  logic pop_w;

  assign change_w = status_i != last_q;
  assign full_w = level_q == LEVEL_W'(TELE_DEPTH);

  // capture is frozen for the whole drain cycle, so push and pop never meet
  assign push_w = change_w && !drain_i && !full_w;
  assign pop_w = tele_tvalid_o && tele_tready_i;

  assign tele_tvalid_o = drain_i && (level_q != '0);
  assign tele_tlast_o = level_q == LEVEL_W'(1);  // beat that empties the queue
  assign tele_tdata_o = mem_q[rd_ptr_q];

  assign tele_level_o = level_q;
  assign has_telemetry_o = has_q;

  always_ff @(posedge clock) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q <= '0;
      last_q <= '0;
      has_q <= 1'b0;
    end else begin
      if (push_w) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
        last_q <= status_i;
      end
      if (pop_w) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;  // wraps, depth is a power of two
      end

      case ({push_w, pop_w})
        2'b10: level_q <= level_q + 1'b1;
        2'b01: level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase

      has_q <= level_q >= HAS_LEVEL;  // one cycle behind the level
    end
  end

  // queue storage
  always_ff @(posedge clock) begin
    if (push_w) begin
      mem_q[wr_ptr_q] <= status_i;
    end
  end

  a_level_bound: assert property (
    @(posedge clock) disable iff (reset_i)
    level_q <= TELE_DEPTH
  ) else $error("telemetry level above queue depth");

endmodule

//--- hw/in_source_mux.sv
`timescale 1ns/100ps
module in_source_mux #(
  parameter usb_bulk_pkg::endpt_t TELE_ENDPOINT = usb_bulk_pkg::DEF_TELE_ENDPOINT,
  parameter int TELE_DEPTH = usb_bulk_pkg::DEF_TELE_DEPTH,
  parameter int READY_LEVEL = usb_bulk_pkg::DEF_READY_LEVEL,
  localparam int LEVEL_W = $clog2(TELE_DEPTH) + 1
) (
  input  logic                 clock,
  input  logic                 reset_i,
  input  usb_bulk_pkg::endpt_t blk_endpt_i,
  input  logic                 blk_in_ready_i,
  input  logic [LEVEL_W-1:0]   tele_level_i,
  output logic                 blk_in_ready_o,
  output logic                 tele_sel_o,
  input  logic                 s_axis_tvalid_i,
  output logic                 s_axis_tready_o,
  input  logic                 s_axis_tlast_i,
  input  logic                 s_axis_tkeep_i,
  input  usb_bulk_pkg::byte_t  s_axis_tdata_i,
  input  logic                 tele_tvalid_i,
  output logic                 tele_tready_o,
  input  logic                 tele_tlast_i,
  input  usb_bulk_pkg::byte_t  tele_tdata_i,
  output logic                 mux_tvalid_o,
  input  logic                 mux_tready_i,
  output logic                 mux_tlast_o,
  output logic                 mux_tkeep_o,
  output usb_bulk_pkg::byte_t  mux_tdata_o
);

  logic sel_q;  // telemetry endpoint is the current bulk target
  logic ready_q;

  always_ff @(posedge clock) begin
    if (reset_i) begin
      sel_q <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      sel_q <= blk_endpt_i == TELE_ENDPOINT;
      // a full telemetry queue must be allowed out even with no user data
      ready_q <= blk_in_ready_i || (tele_level_i >= READY_LEVEL);
    end
  end

  assign tele_sel_o = sel_q;
  assign blk_in_ready_o = ready_q;

  // 2:1 stream select
  assign mux_tvalid_o = sel_q ? tele_tvalid_i : s_axis_tvalid_i;
  assign mux_tlast_o = sel_q ? tele_tlast_i : s_axis_tlast_i;
  assign mux_tkeep_o = sel_q ? 1'b1 : s_axis_tkeep_i;  // every telemetry byte is kept
  assign mux_tdata_o = sel_q ? tele_tdata_i : s_axis_tdata_i;

  assign tele_tready_o = sel_q & mux_tready_i;
  assign s_axis_tready_o = ~sel_q & mux_tready_i;  // user side stalled on telemetry

endmodule

//--- hw/axis_skid.sv
`timescale 1ns/100ps
module axis_skid #(
  parameter int WIDTH = 9
) (
  input  logic             clock,
  input  logic             reset_i,
  input  logic             s_tvalid_i,
  output logic             s_tready_o,
  input  logic [WIDTH-1:0] s_tdata_i,
  output logic             m_tvalid_o,
  input  logic             m_tready_i,
  output logic [WIDTH-1:0] m_tdata_o
);

  logic             m_valid_q;
  logic [WIDTH-1:0] m_data_q;
  logic             sk_valid_q;  // second entry, used only under stall
  logic [WIDTH-1:0] sk_data_q;
  logic             ready_q;

  logic s_fire_w;
  logic advance_w;  // output register free to take a new beat
  logic load_main_w;
  logic load_skid_w;
  logic sk_valid_next_w;

  assign s_fire_w = s_tvalid_i && ready_q;
  assign advance_w = m_tready_i || !m_valid_q;

  // input goes straight to main unless the skid entry is still waiting
  assign load_main_w = advance_w && !sk_valid_q && s_fire_w;
  assign load_skid_w = !advance_w && s_fire_w;

  always_comb begin
    sk_valid_next_w = sk_valid_q;
    if (advance_w) begin
      sk_valid_next_w = 1'b0;  // skid entry moves up to main
    end else if (s_fire_w) begin
      sk_valid_next_w = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset_i) begin
      m_valid_q <= 1'b0;
      sk_valid_q <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      if (advance_w) begin
        m_valid_q <= sk_valid_q || s_fire_w;
      end
      sk_valid_q <= sk_valid_next_w;
      ready_q <= !sk_valid_next_w;  // registered, breaks the ready path
    end
  end

  always_ff @(posedge clock) begin
    if (advance_w && sk_valid_q) begin
      m_data_q <= sk_data_q;
    end else if (load_main_w) begin
      m_data_q <= s_tdata_i;
    end
    if (load_skid_w) begin
      sk_data_q <= s_tdata_i;
    end
  end

  assign s_tready_o = ready_q;
  assign m_tvalid_o = m_valid_q;
  assign m_tdata_o = m_data_q;

  a_hold_on_stall: assert property (
    @(posedge clock) disable iff (reset_i)
    m_tvalid_o && !m_tready_i |=> m_tvalid_o && $stable(m_tdata_o)
  ) else $error("skid output changed while stalled");

endmodule

//--- hw/bulk_in_path.sv
`timescale 1ns/100ps
module bulk_in_path #(
  parameter usb_bulk_pkg::endpt_t TELE_ENDPOINT = usb_bulk_pkg::DEF_TELE_ENDPOINT,
  parameter int TELE_DEPTH = usb_bulk_pkg::DEF_TELE_DEPTH,
  parameter int READY_LEVEL = usb_bulk_pkg::DEF_READY_LEVEL
) (
  input  logic                 clock,
  input  logic                 areset_n,
  input  logic                 usb_reset_i,
  output logic                 reset_no,
  input  usb_bulk_pkg::endpt_t blk_endpt_i,
  input  logic                 blk_cycle_i,
  input  logic                 blk_in_ready_i,
  output logic                 blk_in_ready_o,
  input  usb_bulk_pkg::byte_t  status_i,
  output logic                 has_telemetry_o,
  input  logic                 s_axis_tvalid_i,
  output logic                 s_axis_tready_o,
  input  logic                 s_axis_tlast_i,
  input  logic                 s_axis_tkeep_i,
  input  usb_bulk_pkg::byte_t  s_axis_tdata_i,
  output logic                 m_axis_tvalid_o,
  input  logic                 m_axis_tready_i,
  output logic                 m_axis_tlast_o,
  output logic                 m_axis_tkeep_o,
  output usb_bulk_pkg::byte_t  m_axis_tdata_o
);

  import usb_bulk_pkg::*;

  localparam int LEVEL_W = $clog2(TELE_DEPTH) + 1;
  localparam int SKID_W = DATA_W + 2;  // keep, last and the byte

  logic reset_w;

  logic tele_tvalid_w;
  logic tele_tready_w;
  logic tele_tlast_w;
  byte_t tele_tdata_w;
  logic [LEVEL_W-1:0] tele_level_w;
  logic tele_sel_w;
  logic drain_w;

  logic mux_tvalid_w;
  logic mux_tready_w;
  logic mux_tlast_w;
  logic mux_tkeep_w;
  byte_t mux_tdata_w;
  logic [SKID_W-1:0] skid_out_w;

  usb_reset_sync u_reset_sync (
    .clock      (clock),
    .areset_n   (areset_n),
    .usb_reset_i(usb_reset_i),
    .reset_o    (reset_w),
    .reset_no   (reset_no)
  );

  // telemetry only drains inside a bulk cycle aimed at its endpoint
  assign drain_w = blk_cycle_i & tele_sel_w;

  telemetry_capture #(
    .TELE_DEPTH(TELE_DEPTH)
  ) u_telemetry (
    .clock          (clock),
    .reset_i        (reset_w),
    .status_i       (status_i),
    .drain_i        (drain_w),
    .tele_tvalid_o  (tele_tvalid_w),
    .tele_tready_i  (tele_tready_w),
    .tele_tlast_o   (tele_tlast_w),
    .tele_tdata_o   (tele_tdata_w),
    .tele_level_o   (tele_level_w),
    .has_telemetry_o(has_telemetry_o)
  );

  in_source_mux #(
    .TELE_ENDPOINT(TELE_ENDPOINT),
    .TELE_DEPTH   (TELE_DEPTH),
    .READY_LEVEL  (READY_LEVEL)
  ) u_source_mux (
    .clock          (clock),
    .reset_i        (reset_w),
    .blk_endpt_i    (blk_endpt_i),
    .blk_in_ready_i (blk_in_ready_i),
    .tele_level_i   (tele_level_w),
    .blk_in_ready_o (blk_in_ready_o),
    .tele_sel_o     (tele_sel_w),
    .s_axis_tvalid_i(s_axis_tvalid_i),
    .s_axis_tready_o(s_axis_tready_o),
    .s_axis_tlast_i (s_axis_tlast_i),
    .s_axis_tkeep_i (s_axis_tkeep_i),
    .s_axis_tdata_i (s_axis_tdata_i),
    .tele_tvalid_i  (tele_tvalid_w),
    .tele_tready_o  (tele_tready_w),
    .tele_tlast_i   (tele_tlast_w),
    .tele_tdata_i   (tele_tdata_w),
    .mux_tvalid_o   (mux_tvalid_w),
    .mux_tready_i   (mux_tready_w),
    .mux_tlast_o    (mux_tlast_w),
    .mux_tkeep_o    (mux_tkeep_w),
    .mux_tdata_o    (mux_tdata_w)
  );

  axis_skid #(
    .WIDTH(SKID_W)
  ) u_skid (
    .clock     (clock),
    .reset_i   (reset_w),
    .s_tvalid_i(mux_tvalid_w),
    .s_tready_o(mux_tready_w),
    .s_tdata_i ({mux_tkeep_w, mux_tlast_w, mux_tdata_w}),
    .m_tvalid_o(m_axis_tvalid_o),
    .m_tready_i(m_axis_tready_i),
    .m_tdata_o (skid_out_w)
  );

  assign m_axis_tkeep_o = skid_out_w[DATA_W+1];
  assign m_axis_tlast_o = skid_out_w[DATA_W];
  assign m_axis_tdata_o = skid_out_w[DATA_W-1:0];

endmodule

//--- verification/tb_bulk_in_path.sv
`timescale 1ns/100ps
module tb_bulk_in_path;

  import usb_bulk_pkg::*;

  localparam int TELE_DEPTH = DEF_TELE_DEPTH;
  localparam int HAS_LEVEL = 4;  // level at which has_telemetry_o rises

  logic clock = 1'b0;
  logic areset_n;
  logic usb_reset_i;
  logic reset_no;
  endpt_t blk_endpt_i;
  logic blk_cycle_i;
  logic blk_in_ready_i;
  logic blk_in_ready_o;
  byte_t status_i;
  logic has_telemetry_o;
  logic s_axis_tvalid_i;
  logic s_axis_tready_o;
  logic s_axis_tlast_i;
  logic s_axis_tkeep_i;
  byte_t s_axis_tdata_i;
  logic m_axis_tvalid_o;
  logic m_axis_tready_i;
  logic m_axis_tlast_o;
  logic m_axis_tkeep_o;
  byte_t m_axis_tdata_o;

  integer seed = 32'h6a98;
  int errors = 0;
  int user_beats = 0;
  int tele_beats = 0;

  // model state, valid after the last rising edge
  logic [9:0] user_q[$];  // keep, last, data
  byte_t tele_q[$];
  byte_t m_last;  // last byte the queue took
  logic m_sel;
  logic m_has;
  logic m_rdy;

  // stimulus controls
  logic user_on;
  logic user_fired;
  logic mrdy_rand;
  logic status_on;
  logic ctrl_on;
  logic flags_on;
  logic tele_phase;  // output beats come from telemetry
  logic usb_rst_drv;
  logic cycle_drv;
  endpt_t endpt_drv;

  bulk_in_path #(
    .TELE_ENDPOINT(DEF_TELE_ENDPOINT),
    .TELE_DEPTH   (TELE_DEPTH),
    .READY_LEVEL  (DEF_READY_LEVEL)
  ) i_dut (.*);

  always #2 clock = ~clock;

  function automatic int rand_below(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic endpt_t pick_user_endpt();
    endpt_t e;
    e = endpt_t'($random(seed));
    if (e == DEF_TELE_ENDPOINT) e = e + 1'b1;  // keep away from telemetry
    return e;
  endfunction

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    errors++;
    $display("Mismatch %s: got %0h expected %0h at %0t", name, got, exp, $time);
  endtask

  task automatic report_failure(string what);
    errors++;
    $display("Error: %s at %0t", what, $time);
  endtask

  // compare one output beat with the head of the model
  task automatic check_beat();
    logic [9:0] exp_beat;
    logic have;
    have = 1'b1;
    if (tele_phase) begin
      if (tele_q.size() == 0) begin
        report_failure("telemetry beat left with an empty model queue");
        have = 1'b0;
      end else begin
        exp_beat[9] = 1'b1;
        exp_beat[8] = tele_q.size() == 1;  // beat that empties the queue
        exp_beat[7:0] = tele_q.pop_front();
        tele_beats++;
      end
    end else begin
      if (user_q.size() == 0) begin
        report_failure("user beat left that was never accepted");
        have = 1'b0;
      end else begin
        exp_beat = user_q.pop_front();
        user_beats++;
      end
    end
    if (have) begin
      if (m_axis_tdata_o !== exp_beat[7:0]) begin
        report_mismatch("m_axis_tdata_o", m_axis_tdata_o, exp_beat[7:0]);
      end
      if (m_axis_tlast_o !== exp_beat[8]) begin
        report_mismatch("m_axis_tlast_o", m_axis_tlast_o, exp_beat[8]);
      end
      if (m_axis_tkeep_o !== exp_beat[9]) begin
        report_mismatch("m_axis_tkeep_o", m_axis_tkeep_o, exp_beat[9]);
      end
    end
  endtask

  // one clock: check, drive on the falling edge, then advance the model
  task automatic step();
    logic s_fire;
    logic m_fire;
    logic drain;
    int level;
    @(negedge clock);
    if (flags_on) begin
      if (has_telemetry_o !== m_has) report_mismatch("has_telemetry_o", has_telemetry_o, m_has);
      if (blk_in_ready_o !== m_rdy) report_mismatch("blk_in_ready_o", blk_in_ready_o, m_rdy);
    end
    if (m_sel && s_axis_tready_o !== 1'b0) begin
      report_failure("user stream ready while the telemetry endpoint is selected");
    end
    if (usb_reset_i && m_axis_tvalid_o !== 1'b0) begin
      report_failure("output beat left during bus reset");
    end

    usb_reset_i = usb_rst_drv;
    if (user_fired) s_axis_tvalid_i = 1'b0;
    if (!s_axis_tvalid_i && user_on && rand_below(2) == 0) begin
      s_axis_tvalid_i = 1'b1;
      s_axis_tdata_i = byte_t'($random(seed));
      s_axis_tkeep_i = rand_below(4) != 0;
      s_axis_tlast_i = rand_below(4) == 0;
    end
    m_axis_tready_i = mrdy_rand ? (rand_below(4) != 0) : 1'b1;
    if (status_on && rand_below(4) == 0) status_i = byte_t'($random(seed));
    if (ctrl_on) begin
      blk_in_ready_i = rand_below(2) == 0;
      if (!tele_phase && rand_below(16) == 0) endpt_drv = pick_user_endpt();
    end
    blk_endpt_i = endpt_drv;
    blk_cycle_i = tele_phase ? cycle_drv : (ctrl_on && rand_below(2) == 0);

    // what the coming rising edge does
    s_fire = s_axis_tvalid_i && s_axis_tready_o;
    m_fire = m_axis_tvalid_o && m_axis_tready_i;
    drain = blk_cycle_i && m_sel;
    level = tele_q.size();
    if (s_fire) user_q.push_back({s_axis_tkeep_i, s_axis_tlast_i, s_axis_tdata_i});
    user_fired = s_fire;
    if (m_fire) check_beat();
    if (!drain && status_i != m_last && level < TELE_DEPTH) begin  // full queue drops
      tele_q.push_back(status_i);
      m_last = status_i;
    end
    m_has = level >= HAS_LEVEL;
    m_rdy = blk_in_ready_i || level >= DEF_READY_LEVEL;
    m_sel = blk_endpt_i == DEF_TELE_ENDPOINT;
  endtask

  task automatic wait_user_empty(int limit);
    int n;
    n = 0;
    while ((user_q.size() != 0 || s_axis_tvalid_i) && n < limit) begin
      step();
      n++;
    end
    if (user_q.size() != 0 || s_axis_tvalid_i) begin
      report_failure("timeout waiting for the user stream to drain");
    end
  endtask

  // bulk cycle on the telemetry endpoint until the packet is out
  task automatic run_telemetry(int limit);
    int n;
    tele_phase = 1'b1;
    cycle_drv = 1'b0;
    endpt_drv = DEF_TELE_ENDPOINT;
    step();  // select register follows one edge later
    flags_on = 1'b0;  // level now moves with pops hidden in the DUT
    user_on = 1'b1;  // a new user beat has to stay blocked
    cycle_drv = 1'b1;
    n = 0;
    while (tele_q.size() != 0 && n < limit) begin
      step();
      n++;
    end
    if (tele_q.size() != 0) report_failure("timeout waiting for the telemetry packet");
    tele_phase = 1'b0;
    cycle_drv = 1'b0;
    endpt_drv = pick_user_endpt();
    repeat (2) step();
    flags_on = 1'b1;
  endtask

  initial begin
    int len;
    areset_n = 1'b0;
    usb_reset_i = 1'b0;
    blk_endpt_i = '0;
    blk_cycle_i = 1'b0;
    blk_in_ready_i = 1'b0;
    status_i = '0;
    s_axis_tvalid_i = 1'b0;
    s_axis_tlast_i = 1'b0;
    s_axis_tkeep_i = 1'b0;
    s_axis_tdata_i = '0;
    m_axis_tready_i = 1'b1;
    m_last = '0;
    m_sel = 1'b0;
    m_has = 1'b0;
    m_rdy = 1'b0;
    user_on = 1'b0;
    user_fired = 1'b0;
    mrdy_rand = 1'b0;
    status_on = 1'b0;
    ctrl_on = 1'b0;
    flags_on = 1'b0;
    tele_phase = 1'b0;
    usb_rst_drv = 1'b0;
    cycle_drv = 1'b0;
    endpt_drv = '0;

    repeat (3) @(negedge clock);
    areset_n = 1'b1;
    @(negedge clock);
    if (reset_no !== 1'b0) report_mismatch("reset_no", reset_no, 1'b0);
    @(negedge clock);
    if (reset_no !== 1'b1) report_mismatch("reset_no", reset_no, 1'b1);
    if (m_axis_tvalid_o !== 1'b0) report_mismatch("m_axis_tvalid_o", m_axis_tvalid_o, 1'b0);
    if (has_telemetry_o !== 1'b0) report_mismatch("has_telemetry_o", has_telemetry_o, 1'b0);

    // bus reset with a user beat waiting
    repeat (3) step();
    usb_rst_drv = 1'b1;
    repeat (2) step();
    user_on = 1'b1;
    repeat (6) step();
    usb_rst_drv = 1'b0;
    step();  // core leaves reset on this edge
    flags_on = 1'b1;
    ctrl_on = 1'b1;
    status_on = 1'b1;
    mrdy_rand = 1'b1;

    for (int r = 0; r < 5; r++) begin
      user_on = 1'b1;
      len = 10 + rand_below(150);
      repeat (len) step();
      user_on = 1'b0;
      wait_user_empty(300);
      run_telemetry(400);
    end
    user_on = 1'b1;
    repeat (60) step();
    user_on = 1'b0;
    wait_user_empty(300);

    if (user_beats == 0) report_failure("no user beat reached the output");
    if (tele_beats == 0) report_failure("no telemetry beat reached the output");
    $display("user beats: %0d, telemetry beats: %0d, errors: %0d", user_beats, tele_beats, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
hw/usb_bulk_pkg.sv
hw/usb_reset_sync.sv
hw/telemetry_capture.sv
hw/in_source_mux.sv
hw/axis_skid.sv
hw/bulk_in_path.sv
verification/tb_bulk_in_path.sv

//--- Bender.yml
package:
  name: usb_bulk_in_path

sources:
  - target: any(rtl, test)
    files:
      - hw/usb_bulk_pkg.sv
      - hw/usb_reset_sync.sv
      - hw/telemetry_capture.sv
      - hw/in_source_mux.sv
      - hw/axis_skid.sv
      - hw/bulk_in_path.sv
  - target: test
    files:
      - verification/tb_bulk_in_path.sv
